// File: all.f
+incdir+include
source/board_ctrl_pkg.sv
source/spi_cmd_decode.sv
source/reg_write_exec.sv
source/reg_read_result.sv
source/board_ctrl_top.sv
bench/board_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the board control testbench with verilator and runs it
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module board_ctrl_tb -o board_ctrl_sim

./obj_dir/board_ctrl_sim | tee sim.log

if grep -q "Test passed" sim.log; then
    exit 0
else
    exit 1
fi

// File: include/board_ctrl_tb_tasks.svh
// spi host tasks and expected register model for the board control testbench

localparam int SCLK_HALF = 8;   // reg_clk cycles per sclk phase

logic [REG_DW-1:0] model [2**REG_AW];   // expected readback per address

// one host frame msb first, stops after nbits
task automatic spi_frame(input logic [23:0] tx, input int nbits,
                         output logic [REG_DW-1:0] rx);
    rx = '0;
    @(negedge reg_clk);
    spi_cs_n[1] = 1'b0;
    spi_clk     = 1'b0;
    for (int i = 0; i < nbits; i++) begin
        spi_mosi = tx[23 - i];   // changes while sclk is low
        repeat (SCLK_HALF) @(negedge reg_clk);
        if (i >= 8) begin
            rx = {rx[REG_DW-2:0], spi_miso};   // taken at the rising edge
        end
        spi_clk = 1'b1;
        repeat (SCLK_HALF) @(negedge reg_clk);
        spi_clk = 1'b0;
    end
    repeat (SCLK_HALF) @(negedge reg_clk);
    spi_cs_n[1] = 1'b1;
    repeat (SCLK_HALF) @(negedge reg_clk);
endtask

// only mapped writable addresses keep data
function automatic void model_write(input logic [REG_AW-1:0] addr,
                                    input logic [REG_DW-1:0] data);
    if (addr == RA_PHY_RST) begin
        model[addr] = {12'b0, data[3:0]};
    end else if (addr >= RA_MDIO_CLK && addr <= RA_MDIO_DIR) begin
        model[addr] = {15'b0, data[0]};
    end else if (addr >= RA_TEST_ARRAY && addr < 7'h28) begin
        model[addr] = data;
    end
endfunction

function automatic void model_status();
    model[RA_FW_DATE_LO]  = fw_date[15:0];
    model[RA_FW_DATE_HI]  = fw_date[31:16];
    model[RA_FW_TIME_LO]  = fw_time[15:0];
    model[RA_FW_TIME_HI]  = fw_time[31:16];
    model[RA_FW_TYPE]     = 16'h0001;
    model[RA_MAC_LINK]    = {12'b0, mac_link};
    for (int p = 0; p < ETH_PORTS; p++) begin
        model[7'(8 + 2 * p)] = rx_err[p][15:0];   // low half first
        model[7'(9 + 2 * p)] = rx_err[p][31:16];
    end
    model[RA_MDIO_IN]     = {15'b0, mdio_in};
    model[RA_AURORA_STAT] = {15'b0, aurora_up};
endfunction

task automatic spi_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
    logic [REG_DW-1:0] unused_rx;
    spi_frame({1'b0, addr, data}, 24, unused_rx);
    model_write(addr, data);
endtask

task automatic spi_write_cut(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data,
                             input int nbits);
    logic [REG_DW-1:0] unused_rx;
    spi_frame({1'b0, addr, data}, nbits, unused_rx);
endtask

task automatic read_check(input logic [REG_AW-1:0] addr);
    logic [REG_DW-1:0] rx;
    spi_frame({1'b1, addr, 16'h0000}, 24, rx);
    check_word($sformatf("spi_miso_o word at 0x%02h", addr), model[addr], rx);
endtask

// File: bench/board_ctrl_tb.sv
// board control testbench
// spi host frames against the register slave, pin and readback checks

module board_ctrl_tb;
    import board_ctrl_pkg::*;

    localparam int NUM_FRAMES = 64;
    localparam int TIMEOUT    = (NUM_FRAMES * 24 * 16 + 2000) * 10;

    logic                              reg_clk;
    logic                              arst_n;
    logic                              spi_clk;
    logic [1:0]                        spi_cs_n;
    logic                              spi_mosi;
    logic                              qspi_miso;
    logic [STAT_DW-1:0]                fw_date;
    logic [STAT_DW-1:0]                fw_time;
    logic [ETH_PORTS-1:0]              mac_link;
    logic [ETH_PORTS-1:0][STAT_DW-1:0] rx_err;
    logic                              aurora_up;
    logic                              mdio_in;
    logic                              spi_miso;
    logic                              qspi_cs_n;
    logic                              qspi_mosi;
    logic [ETH_PORTS-1:0]              phy_rst;
    logic                              mdc;
    logic                              mdio_out;
    logic                              mdio_oe;
    integer                            seed = 32'he30b0979;

    board_ctrl_top board_ctrl_top_inst (
        .reg_clk     (reg_clk),
        .arst_n_i    (arst_n),
        .spi_clk_i   (spi_clk),
        .spi_cs_n_i  (spi_cs_n),
        .spi_mosi_i  (spi_mosi),
        .qspi_miso_i (qspi_miso),
        .fw_date_i   (fw_date),
        .fw_time_i   (fw_time),
        .mac_link_i  (mac_link),
        .rx_err_i    (rx_err),
        .aurora_up_i (aurora_up),
        .mdio_i      (mdio_in),
        .spi_miso_o  (spi_miso),
        .qspi_cs_n_o (qspi_cs_n),
        .qspi_mosi_o (qspi_mosi),
        .phy_rst_o   (phy_rst),
        .mdc_o       (mdc),
        .mdio_o      (mdio_out),
        .mdio_oe_o   (mdio_oe)
    );

    task automatic report_mismatch(input string name, input logic [REG_DW-1:0] exp_val,
                                   input logic [REG_DW-1:0] act_val);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
        $display("Test failed");
        $fatal(1, "first mismatch, run stopped");
    endtask

    task automatic check_word(input string name, input logic [REG_DW-1:0] exp_val,
                              input logic [REG_DW-1:0] act_val);
        assert (act_val === exp_val)
        else report_mismatch(name, exp_val, act_val);
    endtask

    `include "board_ctrl_tb_tasks.svh"

    task automatic check_phy_pins();
        check_word("phy_rst_o", model[RA_PHY_RST], 16'(phy_rst));
        check_word("mdc_o", model[RA_MDIO_CLK], 16'(mdc));
        check_word("mdio_o", model[RA_MDIO_DATA], 16'(mdio_out));
        check_word("mdio_oe_o", model[RA_MDIO_DIR], 16'(mdio_oe));
    endtask

    task automatic drive_status();
        @(negedge reg_clk);
        fw_date  = $random(seed);
        fw_time  = $random(seed);
        mac_link = 4'($random(seed));
        for (int p = 0; p < ETH_PORTS; p++) begin
            rx_err[p] = $random(seed);
        end
        {mdio_in, aurora_up} = 2'($random(seed));
        model_status();
    endtask

    // flash selected, register slave deselected
    task automatic check_flash_path();
        @(negedge reg_clk);
        spi_cs_n[0] = 1'b0;
        for (int i = 0; i < 32; i++) begin
            {spi_mosi, qspi_miso} = 2'($random(seed));
            @(posedge reg_clk);
            check_word("qspi_cs_n_o", 16'h0, 16'(qspi_cs_n));
            check_word("qspi_mosi_o", 16'(spi_mosi), 16'(qspi_mosi));
            check_word("spi_miso_o", 16'(qspi_miso), 16'(spi_miso));
            @(negedge reg_clk);
        end
        spi_cs_n[0] = 1'b1;
    endtask

    //------------------------------
    // pin-level assertions
    //------------------------------
    assert property (@(posedge reg_clk) disable iff (!arst_n) (&spi_cs_n) |-> spi_miso)
    else report_mismatch("spi_miso_o", 16'h1, 16'(spi_miso));

    assert property (@(posedge reg_clk) qspi_cs_n == spi_cs_n[0])
    else report_mismatch("qspi_cs_n_o", 16'(spi_cs_n[0]), 16'(qspi_cs_n));

    //------------------------------
    // clock and watchdog
    //------------------------------
    initial begin
        reg_clk = 1'b0;
        forever #5 reg_clk = ~reg_clk;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before all frames finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    //------------------------------
    // stimulus
    //------------------------------
    initial begin
        arst_n    = 1'b0;
        spi_clk   = 1'b0;
        spi_cs_n  = 2'b11;
        spi_mosi  = 1'b0;
        qspi_miso = 1'b0;   // deselected flash must still read as high
        fw_date   = '0;
        fw_time   = '0;
        mac_link  = '0;
        rx_err    = '0;
        aurora_up = 1'b0;
        mdio_in   = 1'b0;
        foreach (model[a]) begin
            model[a] = '0;
        end
        repeat (5) @(negedge reg_clk);
        arst_n = 1'b1;
        @(negedge reg_clk);
        check_phy_pins();   // all zero out of reset
        read_check(RA_TEST_ARRAY);

        drive_status();
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            spi_write(7'(32 + i), 16'($random(seed)));
        end
        for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
            read_check(7'(32 + i));
        end

        // status words, 0x05 and 0x07 are holes
        for (int a = 0; a < 16; a++) begin
            read_check(7'(a));
        end
        read_check(RA_MDIO_IN);
        read_check(RA_AURORA_STAT);
        @(negedge reg_clk);
        mdio_in   = ~mdio_in;
        aurora_up = ~aurora_up;
        model_status();
        read_check(RA_MDIO_IN);
        read_check(RA_AURORA_STAT);
        read_check(7'h30);
        read_check(7'h7F);

        // phy controls, pins may lag cs_n rise by up to two sclk periods
        for (int a = 16; a < 20; a++) begin
            spi_write(7'(a), 16'($random(seed)) | 16'h0001);
            repeat (3 * SCLK_HALF) @(negedge reg_clk);
            check_phy_pins();
            read_check(7'(a));
        end

        spi_write_cut(7'h23, ~model[7'h23], 20);
        read_check(7'h23);
        check_phy_pins();
        spi_write(RA_FW_TYPE, 16'hbeef);
        read_check(RA_FW_TYPE);
        spi_write(RA_RXERR0_LO, ~model[RA_RXERR0_LO]);
        read_check(RA_RXERR0_LO);
        spi_write(RA_MDIO_IN, 16'hffff);
        read_check(RA_MDIO_IN);

        check_flash_path();
        repeat (4) @(negedge reg_clk);
        $display("Test passed");
        $finish;
    end

endmodule

// File: source/board_ctrl_top.sv
// board management register block top level
// spi register slave, register file, read mux, flash pass-through

module board_ctrl_top (
    input  logic                                    reg_clk,
    input  logic                                    arst_n_i,
    input  logic                                    spi_clk_i,
    input  logic [1:0]                              spi_cs_n_i,   // [0] flash, [1] registers
    input  logic                                    spi_mosi_i,
    input  logic                                    qspi_miso_i,
    input  logic [board_ctrl_pkg::STAT_DW-1:0]      fw_date_i,
    input  logic [board_ctrl_pkg::STAT_DW-1:0]      fw_time_i,
    input  logic [board_ctrl_pkg::ETH_PORTS-1:0]    mac_link_i,
    input  logic [board_ctrl_pkg::ETH_PORTS-1:0][board_ctrl_pkg::STAT_DW-1:0] rx_err_i,
    input  logic                                    aurora_up_i,
    input  logic                                    mdio_i,
    output logic                                    spi_miso_o,
    output logic                                    qspi_cs_n_o,
    output logic                                    qspi_mosi_o,
    output logic [board_ctrl_pkg::ETH_PORTS-1:0]    phy_rst_o,
    output logic                                    mdc_o,
    output logic                                    mdio_o,
    output logic                                    mdio_oe_o
);
    import board_ctrl_pkg::*;

    reg_wr_t           reg_wr;
    logic [REG_AW-1:0] rd_addr;
    logic [REG_DW-1:0] rd_word;
    logic              reg_miso;
    board_status_t     status;
    phy_ctrl_t         phy_ctrl;
    logic [REG_DW-1:0] test_array [TEST_ARRAY_COUNT];

    //------------------------------
    // register slave
    //------------------------------
    spi_cmd_decode spi_cmd_decode_inst (
        .reg_clk    (reg_clk),
        .arst_n_i   (arst_n_i),
        .spi_clk_i  (spi_clk_i),
        .spi_cs_n_i (spi_cs_n_i[CS_REG]),
        .spi_mosi_i (spi_mosi_i),
        .rd_word_i  (rd_word),
        .spi_miso_o (reg_miso),
        .reg_wr_o   (reg_wr),
        .rd_addr_o  (rd_addr)
    );

    reg_write_exec reg_write_exec_inst (
        .reg_clk      (reg_clk),
        .arst_n_i     (arst_n_i),
        .reg_wr_i     (reg_wr),
        .phy_ctrl_o   (phy_ctrl),
        .test_array_o (test_array)
    );

    assign status = '{fw_date:   fw_date_i,
                      fw_time:   fw_time_i,
                      mac_link:  mac_link_i,
                      rx_err:    rx_err_i,
                      mdio_in:   mdio_i,
                      aurora_up: aurora_up_i};

    reg_read_result reg_read_result_inst (
        .rd_addr_i    (rd_addr),
        .status_i     (status),
        .phy_ctrl_i   (phy_ctrl),
        .test_array_i (test_array),
        .rd_word_o    (rd_word)
    );

    //------------------------------
    // phy pins, mdio pad lives in the board wrapper
    //------------------------------
    assign phy_rst_o = phy_ctrl.phy_rst;
    assign mdc_o     = phy_ctrl.mdc;
    assign mdio_o    = phy_ctrl.mdio_data;
    assign mdio_oe_o = phy_ctrl.mdio_dir;

    //------------------------------
    // flash pass-through and miso merge
    //------------------------------
    assign qspi_cs_n_o = spi_cs_n_i[CS_FLASH];
    assign qspi_mosi_o = spi_mosi_i;

    // an unselected source floats high, the selected one pulls low
    assign spi_miso_o = (qspi_miso_i | spi_cs_n_i[CS_FLASH])
                        & (reg_miso | spi_cs_n_i[CS_REG]);

endmodule

// File: source/reg_read_result.sv
// register read multiplexer
// forms the 16-bit result word for a register address

module reg_read_result (
    input  logic [board_ctrl_pkg::REG_AW-1:0] rd_addr_i,
    input  board_ctrl_pkg::board_status_t     status_i,
    input  board_ctrl_pkg::phy_ctrl_t         phy_ctrl_i,
    input  logic [board_ctrl_pkg::REG_DW-1:0] test_array_i [board_ctrl_pkg::TEST_ARRAY_COUNT],
    output logic [board_ctrl_pkg::REG_DW-1:0] rd_word_o
);
    import board_ctrl_pkg::*;

    logic                   ta_hit;
    logic [TA_IDX_W-1:0]    ta_idx;
    logic                   rxerr_hit;
    logic [RXERR_IDX_W-1:0] rxerr_off;   // {port, half}

    // low half on even address, high half on odd
    function automatic logic [REG_DW-1:0] pick_half(
        input logic [STAT_DW-1:0] value,
        input logic               upper
    );
        return upper ? value[STAT_DW-1:REG_DW] : value[REG_DW-1:0];
    endfunction

    //------------------------------
    // window decode
    //------------------------------
    assign ta_hit = (rd_addr_i >= RA_TEST_ARRAY)
                    && (rd_addr_i < REG_AW'(RA_TEST_ARRAY + TEST_ARRAY_COUNT));
    assign ta_idx = TA_IDX_W'(rd_addr_i - RA_TEST_ARRAY);

    assign rxerr_hit = (rd_addr_i >= RA_RXERR0_LO) && (rd_addr_i <= RA_RXERR3_HI);
    assign rxerr_off = RXERR_IDX_W'(rd_addr_i - RA_RXERR0_LO);

    //------------------------------
    // result mux
    //------------------------------
    always_comb begin
        rd_word_o = '0;   // unmapped reads as zero
        case (rd_addr_i)
            RA_FW_DATE_LO,
            RA_FW_DATE_HI: begin
                rd_word_o = pick_half(status_i.fw_date, rd_addr_i[0]);
            end
            RA_FW_TIME_LO,
            RA_FW_TIME_HI: begin
                rd_word_o = pick_half(status_i.fw_time, rd_addr_i[0]);
            end
            RA_FW_TYPE:     rd_word_o = FW_TYPE;
            RA_MAC_LINK:    rd_word_o = REG_DW'(status_i.mac_link);
            RA_PHY_RST:     rd_word_o = REG_DW'(phy_ctrl_i.phy_rst);
            RA_MDIO_CLK:    rd_word_o = REG_DW'(phy_ctrl_i.mdc);
            RA_MDIO_DATA:   rd_word_o = REG_DW'(phy_ctrl_i.mdio_data);
            RA_MDIO_DIR:    rd_word_o = REG_DW'(phy_ctrl_i.mdio_dir);
            RA_MDIO_IN:     rd_word_o = REG_DW'(status_i.mdio_in);      // live pin level
            RA_AURORA_STAT: rd_word_o = REG_DW'(status_i.aurora_up);
            default: begin
                if (rxerr_hit) begin
                    rd_word_o = pick_half(status_i.rx_err[rxerr_off[RXERR_IDX_W-1:1]],
                                          rxerr_off[0]);
                end else if (ta_hit) begin
                    rd_word_o = test_array_i[ta_idx];
                end
            end
        endcase
    end

endmodule

// File: source/reg_write_exec.sv
// writable register file
// applies decoded register writes to the phy controls and scratch array

module reg_write_exec (
    input  logic                              reg_clk,
    input  logic                              arst_n_i,
    input  board_ctrl_pkg::reg_wr_t           reg_wr_i,
    output board_ctrl_pkg::phy_ctrl_t         phy_ctrl_o,
    output logic [board_ctrl_pkg::REG_DW-1:0] test_array_o [board_ctrl_pkg::TEST_ARRAY_COUNT]
);
    import board_ctrl_pkg::*;

    logic                ta_hit;
    logic [TA_IDX_W-1:0] ta_idx;

    //------------------------------
    // scratch window decode
    //------------------------------
    // 0x20..0x27, anything above falls through
    assign ta_hit = (reg_wr_i.addr >= RA_TEST_ARRAY)
                    && (reg_wr_i.addr < REG_AW'(RA_TEST_ARRAY + TEST_ARRAY_COUNT));
    assign ta_idx = TA_IDX_W'(reg_wr_i.addr - RA_TEST_ARRAY);

    //------------------------------
    // register updates
    //------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phy_ctrl_o <= '0;   // mdio output disabled
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                test_array_o[i] <= '0;
            end
        end else if (reg_wr_i.en) begin
            case (reg_wr_i.addr)
                RA_PHY_RST: begin
                    phy_ctrl_o.phy_rst <= reg_wr_i.data[ETH_PORTS-1:0];
                end
                RA_MDIO_CLK: begin
                    phy_ctrl_o.mdc <= reg_wr_i.data[0];   // bit-bang mdc
                end
                RA_MDIO_DATA: begin
                    phy_ctrl_o.mdio_data <= reg_wr_i.data[0];
                end
                RA_MDIO_DIR: begin
                    phy_ctrl_o.mdio_dir <= reg_wr_i.data[0];
                end
                default: begin
                    // read-only and unmapped addresses are ignored
                    if (ta_hit) begin
                        test_array_o[ta_idx] <= reg_wr_i.data;
                    end
                end
            endcase
        end
    end

endmodule

// File: source/spi_cmd_decode.sv
// spi register slave frame decoder
// samples the spi pins in reg_clk, decodes 24-bit frames into
// write strobes and read addresses, shifts read data out on miso

module spi_cmd_decode (
    input  logic                              reg_clk,
    input  logic                              arst_n_i,
    input  logic                              spi_clk_i,
    input  logic                              spi_cs_n_i,
    input  logic                              spi_mosi_i,
    input  logic [board_ctrl_pkg::REG_DW-1:0] rd_word_i,
    output logic                              spi_miso_o,
    output board_ctrl_pkg::reg_wr_t           reg_wr_o,
    output logic [board_ctrl_pkg::REG_AW-1:0] rd_addr_o
);
    import board_ctrl_pkg::*;

    logic [1:0]           sclk_sync;
    logic [1:0]           cs_sync;
    logic [1:0]           mosi_sync;
    logic                 sclk_q;
    logic                 cs_q;
    logic                 sclk_rise;
    logic                 sclk_fall;
    logic                 frame_start;
    logic                 hdr_done;
    logic                 data_done;

    spi_state_e           state_q;
    spi_cmd_e             cmd_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    logic                 load_q;      // read word fetch, one cycle after header
    logic                 wr_en_q;
    logic                 miso_q;

    logic [REG_DW-1:0]    shift_in_q;
    logic [REG_DW-1:0]    shift_out_q;
    logic [REG_AW-1:0]    addr_q;

    //------------------------------
    // pin sync and edge detect
    //------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            sclk_q    <= 1'b0;
            cs_q      <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_clk_i};
            cs_sync   <= {cs_sync[0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sclk_q    <= sclk_sync[1];
            cs_q      <= cs_sync[1];
        end
    end

    assign sclk_rise   = sclk_sync[1] & ~sclk_q;
    assign sclk_fall   = ~sclk_sync[1] & sclk_q;
    assign frame_start = cs_q & ~cs_sync[1];   // cs_n falling

    assign hdr_done  = sclk_rise && (state_q == ST_ADDR)
                       && (bit_cnt_q == BIT_CNT_W'(HDR_BITS - 1));
    assign data_done = sclk_rise && (state_q == ST_DATA)
                       && (bit_cnt_q == BIT_CNT_W'(REG_DW - 1));

    //------------------------------
    // frame fsm
    //------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            cmd_q     <= CMD_WRITE;
            bit_cnt_q <= '0;
            load_q    <= 1'b0;
            wr_en_q   <= 1'b0;
            miso_q    <= 1'b0;
        end else begin
            load_q  <= hdr_done;
            wr_en_q <= data_done && (cmd_q == CMD_WRITE);
            if (cs_sync[1]) begin   // deselected, drop any partial frame
                state_q <= ST_IDLE;
                miso_q  <= 1'b0;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        miso_q    <= 1'b0;
                        bit_cnt_q <= '0;
                        if (frame_start) begin
                            state_q <= ST_ADDR;
                        end
                    end
                    ST_ADDR: begin
                        if (sclk_rise) begin
                            if (bit_cnt_q == '0) begin
                                cmd_q <= spi_cmd_e'(mosi_sync[1]);  // opcode is first bit
                            end
                            bit_cnt_q <= hdr_done ? '0 : bit_cnt_q + 1'b1;
                            if (hdr_done) begin
                                state_q <= ST_DATA;
                            end
                        end
                    end
                    ST_DATA: begin
                        if (sclk_fall) begin
                            miso_q <= (cmd_q == CMD_READ) && shift_out_q[REG_DW-1];
                        end
                        if (sclk_rise) begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                        if (data_done) begin
                            state_q <= ST_IDLE;   // wait for next cs_n fall
                        end
                    end
                    default: state_q <= ST_IDLE;
                endcase
            end
        end
    end

    //------------------------------
    // shift registers
    //------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shift_in_q  <= '0;
            shift_out_q <= '0;
            addr_q      <= '0;
        end else begin
            if (sclk_rise && (state_q != ST_IDLE)) begin
                shift_in_q <= {shift_in_q[REG_DW-2:0], mosi_sync[1]};
            end
            if (hdr_done) begin
                addr_q <= {shift_in_q[REG_AW-2:0], mosi_sync[1]};
            end
            if (load_q) begin
                shift_out_q <= rd_word_i;
            end else if (sclk_fall && (state_q == ST_DATA)) begin
                shift_out_q <= {shift_out_q[REG_DW-2:0], 1'b0};
            end
        end
    end

    assign spi_miso_o = miso_q;
    assign rd_addr_o  = addr_q;
    assign reg_wr_o   = '{en: wr_en_q, addr: addr_q, data: shift_in_q};  // data = last 16 bits

endmodule

// File: source/board_ctrl_pkg.sv
// board management register block
// shared widths, register address map, enums and bus structs

package board_ctrl_pkg;

    //------------------------------
    // widths and constants
    //------------------------------
    localparam int REG_DW           = 16;  // register data width
    localparam int REG_AW           = 7;   // register address width
    localparam int ETH_PORTS        = 4;
    localparam int TEST_ARRAY_COUNT = 8;   // scratch registers
    localparam int STAT_DW          = 32;  // date, time and error counters

    localparam logic [REG_DW-1:0] FW_TYPE = 16'h0001;

    // spi frame layout: opcode + address, then data
    localparam int HDR_BITS  = 1 + REG_AW;
    localparam int BIT_CNT_W = $clog2(REG_DW);

    // index widths inside the address map
    localparam int TA_IDX_W    = $clog2(TEST_ARRAY_COUNT);
    localparam int RXERR_IDX_W = $clog2(2 * ETH_PORTS);  // port + half

    // chip select lines
    localparam int CS_FLASH = 0;
    localparam int CS_REG   = 1;

    //------------------------------
    // register address map
    //------------------------------
    // 32-bit values take two addresses, low half first
    typedef enum logic [REG_AW-1:0] {
        RA_FW_DATE_LO  = 7'h00,
        RA_FW_DATE_HI  = 7'h01,
        RA_FW_TIME_LO  = 7'h02,
        RA_FW_TIME_HI  = 7'h03,
        RA_FW_TYPE     = 7'h04,
        RA_MAC_LINK    = 7'h06,
        RA_RXERR0_LO   = 7'h08,
        RA_RXERR0_HI   = 7'h09,
        RA_RXERR1_LO   = 7'h0A,
        RA_RXERR1_HI   = 7'h0B,
        RA_RXERR2_LO   = 7'h0C,
        RA_RXERR2_HI   = 7'h0D,
        RA_RXERR3_LO   = 7'h0E,
        RA_RXERR3_HI   = 7'h0F,
        RA_PHY_RST     = 7'h10,
        RA_MDIO_CLK    = 7'h11,
        RA_MDIO_DATA   = 7'h12,
        RA_MDIO_DIR    = 7'h13,
        RA_MDIO_IN     = 7'h14,
        RA_AURORA_STAT = 7'h15,
        RA_TEST_ARRAY  = 7'h20   // scratch 0x20..0x27
    } reg_addr_e;

    //------------------------------
    // spi decoder types
    //------------------------------
    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } spi_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } spi_state_e;

    //------------------------------
    // structs
    //------------------------------
    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [STAT_DW-1:0]                fw_date;
        logic [STAT_DW-1:0]                fw_time;
        logic [ETH_PORTS-1:0]              mac_link;
        logic [ETH_PORTS-1:0][STAT_DW-1:0] rx_err;   // crc error counters
        logic                              mdio_in;
        logic                              aurora_up;
    } board_status_t;

    typedef struct packed {
        logic [ETH_PORTS-1:0] phy_rst;
        logic                 mdc;
        logic                 mdio_data;
        logic                 mdio_dir;   // 1 = drive mdio
    } phy_ctrl_t;

endpackage
